/* src/ooo_params.svh */
`ifndef OOO_PARAMS_SVH
`define OOO_PARAMS_SVH

// data path width
`define XLEN 32

// register counts, architectural and physical
`define NUM_AREGS 32
`define NUM_PREGS 64

// window sizes
`define ROB_DEPTH 16
`define IQ_DEPTH 8

// multiplier pipeline depth in registers
`define MUL_STAGES 3

`endif

/* src/isa_pkg.sv */
`include "ooo_params.svh"

package isa_pkg;

    // operation encodings seen on the instruction stream
    typedef enum logic [2:0] {
        ADD  = 3'd0,
        SUB  = 3'd1,
        AND  = 3'd2,
        XOR  = 3'd3,
        ADDI = 3'd4,
        MUL  = 3'd5
    } opcode_t;

    // architectural register number
    typedef logic [$clog2(`NUM_AREGS)-1:0] areg_t;

    // raw immediate, sign-extended by the ALU
    typedef logic [15:0] imm_t;

endpackage

/* src/ooo_pkg.sv */
`include "ooo_params.svh"

package ooo_pkg;

    // physical register tag, also the wake-up tag
    typedef logic [$clog2(`NUM_PREGS)-1:0] preg_t;

    // position in the reorder buffer
    typedef logic [$clog2(`ROB_DEPTH)-1:0] rob_idx_t;

    // register value and PC width
    typedef logic [`XLEN-1:0] word_t;

endpackage

/* src/rename_unit.sv */
`include "ooo_params.svh"

module rename_unit
    import isa_pkg::*, ooo_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,

    input  logic     in_valid,
    input  opcode_t  in_opcode,
    input  areg_t    in_rd,
    input  areg_t    in_rs1,
    input  areg_t    in_rs2,
    input  imm_t     in_imm,
    input  word_t    in_pc,

    input  logic     rob_full,
    input  logic     iq_full,
    input  rob_idx_t alloc_idx,

    input  logic     free0_valid,
    input  preg_t    free0_ptag,
    input  logic     free1_valid,
    input  preg_t    free1_ptag,

    output logic     stall,

    output logic     ren_valid,
    output opcode_t  ren_opcode,
    output preg_t    ren_ptag_d,
    output preg_t    ren_ptag_s1,
    output preg_t    ren_ptag_s2,
    output imm_t     ren_imm,
    output rob_idx_t ren_rob_idx,
    output preg_t    ren_old_ptag,
    output areg_t    ren_rd,
    output word_t    ren_pc
);

    // current architectural to physical mapping
    preg_t map_tbl [`NUM_AREGS];

    // one bit per physical register, set when it can be handed out
    logic [`NUM_PREGS-1:0] free_bm;
    preg_t new_tag;

    // lowest free tag wins
    always_comb begin
        new_tag = '0;
        for (int i = `NUM_PREGS - 1; i >= 0; i--) begin
            if (free_bm[i]) begin
                new_tag = preg_t'(i);
            end
        end
    end

    // no tag left, or no room downstream
    assign stall     = ~(|free_bm) | rob_full | iq_full;
    assign ren_valid = in_valid & ~stall;

    assign ren_opcode   = in_opcode;
    assign ren_ptag_d   = new_tag;
    assign ren_ptag_s1  = map_tbl[in_rs1];
    assign ren_ptag_s2  = map_tbl[in_rs2];
    assign ren_imm      = in_imm;
    assign ren_rob_idx  = alloc_idx;
    assign ren_old_ptag = map_tbl[in_rd];
    assign ren_rd       = in_rd;
    assign ren_pc       = in_pc;

    // identity map out of reset
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < `NUM_AREGS; i++) begin
                map_tbl[i] <= preg_t'(i);
            end
        end else if (ren_valid) begin
            map_tbl[in_rd] <= new_tag;
        end
    end

    // upper half of the physical file starts out free
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            free_bm <= {{(`NUM_PREGS - `NUM_AREGS){1'b1}}, {`NUM_AREGS{1'b0}}};
        end else begin
            if (free0_valid) begin
                free_bm[free0_ptag] <= 1'b1;
            end
            if (free1_valid) begin
                free_bm[free1_ptag] <= 1'b1;
            end
            // a tag being freed is never the one handed out this cycle
            if (ren_valid) begin
                free_bm[new_tag] <= 1'b0;
            end
        end
    end

endmodule

/* src/issue_queue.sv */
`include "ooo_params.svh"

module issue_queue
    import isa_pkg::*, ooo_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,

    input  logic     ren_valid,
    input  opcode_t  ren_opcode,
    input  preg_t    ren_ptag_d,
    input  preg_t    ren_ptag_s1,
    input  preg_t    ren_ptag_s2,
    input  imm_t     ren_imm,
    input  rob_idx_t ren_rob_idx,

    input  logic     cmp0_valid,
    input  preg_t    cmp0_ptag,
    input  logic     cmp1_valid,
    input  preg_t    cmp1_ptag,

    output logic     iq_full,

    output logic     alu_issue,
    output opcode_t  alu_op,
    output preg_t    alu_ptag_s1,
    output preg_t    alu_ptag_s2,
    output imm_t     alu_imm,
    output preg_t    alu_ptag_d,
    output rob_idx_t alu_rob,

    output logic     mul_issue,
    output preg_t    mul_ptag_s1,
    output preg_t    mul_ptag_s2,
    output preg_t    mul_ptag_d,
    output rob_idx_t mul_rob
);

    localparam int IW = $clog2(`IQ_DEPTH);

    logic [`IQ_DEPTH-1:0] q_valid;
    opcode_t              q_op   [`IQ_DEPTH];
    preg_t                q_s1   [`IQ_DEPTH];
    preg_t                q_s2   [`IQ_DEPTH];
    preg_t                q_d    [`IQ_DEPTH];
    imm_t                 q_imm  [`IQ_DEPTH];
    rob_idx_t             q_rob  [`IQ_DEPTH];
    // older[i] has bit j set when entry j was dispatched before entry i
    logic [`IQ_DEPTH-1:0] older  [`IQ_DEPTH];

    logic [`NUM_PREGS-1:0] rdy_bm;
    logic [`IQ_DEPTH-1:0]  req_alu, req_mul, sel_alu, sel_mul;
    logic [IW-1:0]         ins_slot, alu_slot, mul_slot;

    always_comb begin
        logic src_ok;
        ins_slot = '0;
        alu_slot = '0;
        mul_slot = '0;
        for (int i = `IQ_DEPTH - 1; i >= 0; i--) begin
            // ADDI has no second source
            src_ok = rdy_bm[q_s1[i]] & ((q_op[i] == ADDI) | rdy_bm[q_s2[i]]);
            req_alu[i] = q_valid[i] & src_ok & (q_op[i] != MUL);
            req_mul[i] = q_valid[i] & src_ok & (q_op[i] == MUL);
            if (!q_valid[i]) begin
                ins_slot = IW'(i);
            end
        end
        // oldest requester per lane
        for (int i = `IQ_DEPTH - 1; i >= 0; i--) begin
            sel_alu[i] = req_alu[i] & ~(|(req_alu & older[i]));
            sel_mul[i] = req_mul[i] & ~(|(req_mul & older[i]));
            if (sel_alu[i]) begin
                alu_slot = IW'(i);
            end
            if (sel_mul[i]) begin
                mul_slot = IW'(i);
            end
        end
    end

    assign iq_full = &q_valid;

    assign alu_issue   = |sel_alu;
    assign alu_op      = q_op[alu_slot];
    assign alu_ptag_s1 = q_s1[alu_slot];
    assign alu_ptag_s2 = q_s2[alu_slot];
    assign alu_imm     = q_imm[alu_slot];
    assign alu_ptag_d  = q_d[alu_slot];
    assign alu_rob     = q_rob[alu_slot];

    assign mul_issue   = |sel_mul;
    assign mul_ptag_s1 = q_s1[mul_slot];
    assign mul_ptag_s2 = q_s2[mul_slot];
    assign mul_ptag_d  = q_d[mul_slot];
    assign mul_rob     = q_rob[mul_slot];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            q_valid <= '0;
            rdy_bm  <= '1;
            for (int i = 0; i < `IQ_DEPTH; i++) begin
                older[i] <= '0;
            end
        end else begin
            // wake-up from both completion ports
            if (cmp0_valid) begin
                rdy_bm[cmp0_ptag] <= 1'b1;
            end
            if (cmp1_valid) begin
                rdy_bm[cmp1_ptag] <= 1'b1;
            end
            q_valid <= q_valid & ~sel_alu & ~sel_mul;
            if (ren_valid) begin
                rdy_bm[ren_ptag_d] <= 1'b0;
                q_valid[ins_slot]  <= 1'b1;
                // newcomer is younger than everything already held
                for (int i = 0; i < `IQ_DEPTH; i++) begin
                    older[i][ins_slot] <= 1'b0;
                end
                older[ins_slot] <= q_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ren_valid) begin
            q_op[ins_slot]  <= ren_opcode;
            q_s1[ins_slot]  <= ren_ptag_s1;
            q_s2[ins_slot]  <= ren_ptag_s2;
            q_d[ins_slot]   <= ren_ptag_d;
            q_imm[ins_slot] <= ren_imm;
            q_rob[ins_slot] <= ren_rob_idx;
        end
    end

endmodule

/* src/exec_unit.sv */
`include "ooo_params.svh"

module exec_unit
    import isa_pkg::*, ooo_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,

    input  logic     alu_issue,
    input  opcode_t  alu_op,
    input  preg_t    alu_ptag_s1,
    input  preg_t    alu_ptag_s2,
    input  imm_t     alu_imm,
    input  preg_t    alu_ptag_d,
    input  rob_idx_t alu_rob,

    input  logic     mul_issue,
    input  preg_t    mul_ptag_s1,
    input  preg_t    mul_ptag_s2,
    input  preg_t    mul_ptag_d,
    input  rob_idx_t mul_rob,

    output logic     cmp0_valid,
    output preg_t    cmp0_ptag,
    output rob_idx_t cmp0_rob,
    output word_t    cmp0_data,

    output logic     cmp1_valid,
    output preg_t    cmp1_ptag,
    output rob_idx_t cmp1_rob,
    output word_t    cmp1_data
);

    localparam int LAST = `MUL_STAGES - 1;

    word_t prf [`NUM_PREGS];

    word_t a_op1, a_op2, imm_ext, alu_res;

    // multiplier pipe, stage 0 holds operands, later stages the product
    logic [`MUL_STAGES-1:0] m_v;
    preg_t                  m_tag [`MUL_STAGES];
    rob_idx_t               m_rob [`MUL_STAGES];
    word_t                  m_a, m_b;
    word_t                  m_p   [1:LAST];

    assign a_op1   = prf[alu_ptag_s1];
    assign a_op2   = prf[alu_ptag_s2];
    assign imm_ext = {{(`XLEN - 16){alu_imm[15]}}, alu_imm};

    always_comb begin
        case (alu_op)
            ADD:     alu_res = a_op1 + a_op2;
            SUB:     alu_res = a_op1 - a_op2;
            AND:     alu_res = a_op1 & a_op2;
            XOR:     alu_res = a_op1 ^ a_op2;
            ADDI:    alu_res = a_op1 + imm_ext;
            default: alu_res = '0;
        endcase
    end

    // register file is written as each result is broadcast
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < `NUM_PREGS; i++) begin
                prf[i] <= '0;
            end
        end else begin
            if (cmp0_valid) begin
                prf[cmp0_ptag] <= cmp0_data;
            end
            if (cmp1_valid) begin
                prf[cmp1_ptag] <= cmp1_data;
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cmp0_valid <= 1'b0;
            m_v        <= '0;
        end else begin
            cmp0_valid <= alu_issue;
            m_v        <= {m_v[LAST-1:0], mul_issue};
        end
    end

    always_ff @(posedge clk) begin
        cmp0_ptag <= alu_ptag_d;
        cmp0_rob  <= alu_rob;
        cmp0_data <= alu_res;
        m_a       <= prf[mul_ptag_s1];
        m_b       <= prf[mul_ptag_s2];
        m_tag[0]  <= mul_ptag_d;
        m_rob[0]  <= mul_rob;
        // low half of the product only
        m_p[1]    <= m_a * m_b;
        for (int s = 1; s <= LAST; s++) begin
            m_tag[s] <= m_tag[s-1];
            m_rob[s] <= m_rob[s-1];
        end
        for (int s = 2; s <= LAST; s++) begin
            m_p[s] <= m_p[s-1];
        end
    end

    assign cmp1_valid = m_v[LAST];
    assign cmp1_ptag  = m_tag[LAST];
    assign cmp1_rob   = m_rob[LAST];
    assign cmp1_data  = m_p[LAST];

endmodule

/* src/reorder_buffer.sv */
`include "ooo_params.svh"

module reorder_buffer
    import isa_pkg::*, ooo_pkg::*;
(
    input  logic     clk,
    input  logic     rstn,

    // allocation from rename
    input  logic     ren_valid,
    input  rob_idx_t ren_rob_idx,
    input  areg_t    ren_rd,
    input  preg_t    ren_old_ptag,
    input  preg_t    ren_ptag_d,
    input  word_t    ren_pc,

    // completion ports, ALU then MUL
    input  logic     cmp0_valid,
    input  preg_t    cmp0_ptag,
    input  rob_idx_t cmp0_rob,
    input  word_t    cmp0_data,
    input  logic     cmp1_valid,
    input  preg_t    cmp1_ptag,
    input  rob_idx_t cmp1_rob,
    input  word_t    cmp1_data,

    output rob_idx_t alloc_idx,
    output logic     rob_full,

    output logic     retire0_valid,
    output areg_t    retire0_rd,
    output word_t    retire0_data,
    output word_t    retire0_pc,
    output logic     retire1_valid,
    output areg_t    retire1_rd,
    output word_t    retire1_data,
    output word_t    retire1_pc,

    // old mappings handed back to the free list
    output logic     free0_valid,
    output preg_t    free0_ptag,
    output logic     free1_valid,
    output preg_t    free1_ptag
);

    localparam int CW = $clog2(`ROB_DEPTH) + 1;

    rob_idx_t head, head_nxt, tail;
    logic [CW-1:0] count;

    logic [`ROB_DEPTH-1:0] e_valid;
    logic [`ROB_DEPTH-1:0] e_done;
    areg_t                 e_rd   [`ROB_DEPTH];
    preg_t                 e_old  [`ROB_DEPTH];
    preg_t                 e_ptag [`ROB_DEPTH];
    word_t                 e_data [`ROB_DEPTH];
    word_t                 e_pc   [`ROB_DEPTH];

    logic ret0, ret1;
    logic cmp0_hit, cmp1_hit;

    assign head_nxt  = head + rob_idx_t'(1);
    assign alloc_idx = tail;
    assign rob_full  = (count == CW'(`ROB_DEPTH));

    // second slot only retires behind the first
    assign ret0 = e_valid[head] & e_done[head];
    assign ret1 = ret0 & e_valid[head_nxt] & e_done[head_nxt];

    assign retire0_valid = ret0;
    assign retire0_rd    = e_rd[head];
    assign retire0_data  = e_data[head];
    assign retire0_pc    = e_pc[head];
    assign retire1_valid = ret1;
    assign retire1_rd    = e_rd[head_nxt];
    assign retire1_data  = e_data[head_nxt];
    assign retire1_pc    = e_pc[head_nxt];

    assign free0_valid = ret0;
    assign free0_ptag  = e_old[head];
    assign free1_valid = ret1;
    assign free1_ptag  = e_old[head_nxt];

    // completion is by index; the tag must match the entry it names
    assign cmp0_hit = cmp0_valid & e_valid[cmp0_rob] & (e_ptag[cmp0_rob] == cmp0_ptag);
    assign cmp1_hit = cmp1_valid & e_valid[cmp1_rob] & (e_ptag[cmp1_rob] == cmp1_ptag);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            head    <= '0;
            tail    <= '0;
            count   <= '0;
            e_valid <= '0;
            e_done  <= '0;
        end else begin
            if (cmp0_hit) begin
                e_done[cmp0_rob] <= 1'b1;
            end
            if (cmp1_hit) begin
                e_done[cmp1_rob] <= 1'b1;
            end
            if (ret0) begin
                e_valid[head] <= 1'b0;
            end
            if (ret1) begin
                e_valid[head_nxt] <= 1'b0;
            end
            // tail slot is never the head while there is room
            if (ren_valid) begin
                e_valid[ren_rob_idx] <= 1'b1;
                e_done[ren_rob_idx]  <= 1'b0;
                tail                 <= tail + rob_idx_t'(1);
            end
            head  <= head + rob_idx_t'(ret0) + rob_idx_t'(ret1);
            count <= count + CW'(ren_valid) - CW'(ret0) - CW'(ret1);
        end
    end

    always_ff @(posedge clk) begin
        if (ren_valid) begin
            e_rd[ren_rob_idx]   <= ren_rd;
            e_old[ren_rob_idx]  <= ren_old_ptag;
            e_ptag[ren_rob_idx] <= ren_ptag_d;
            e_pc[ren_rob_idx]   <= ren_pc;
        end
        if (cmp0_hit) begin
            e_data[cmp0_rob] <= cmp0_data;
        end
        if (cmp1_hit) begin
            e_data[cmp1_rob] <= cmp1_data;
        end
    end

endmodule

/* src/ooo_core.sv */
`include "ooo_params.svh"

module ooo_core
    import isa_pkg::*, ooo_pkg::*;
(
    input  logic    clk,
    input  logic    rstn,

    input  logic    in_valid,
    input  opcode_t in_opcode,
    input  areg_t   in_rd,
    input  areg_t   in_rs1,
    input  areg_t   in_rs2,
    input  imm_t    in_imm,
    input  word_t   in_pc,

    output logic    stall,

    output logic    retire0_valid,
    output areg_t   retire0_rd,
    output word_t   retire0_data,
    output word_t   retire0_pc,
    output logic    retire1_valid,
    output areg_t   retire1_rd,
    output word_t   retire1_data,
    output word_t   retire1_pc
);

    // renamed instruction
    logic     ren_valid;
    opcode_t  ren_opcode;
    preg_t    ren_ptag_d, ren_ptag_s1, ren_ptag_s2, ren_old_ptag;
    imm_t     ren_imm;
    rob_idx_t ren_rob_idx;
    areg_t    ren_rd;
    word_t    ren_pc;

    // back pressure and ROB allocation
    rob_idx_t alloc_idx;
    logic     rob_full, iq_full;

    // issue ports
    logic     alu_issue, mul_issue;
    opcode_t  alu_op;
    preg_t    alu_ptag_s1, alu_ptag_s2, alu_ptag_d;
    preg_t    mul_ptag_s1, mul_ptag_s2, mul_ptag_d;
    imm_t     alu_imm;
    rob_idx_t alu_rob, mul_rob;

    // completion broadcast
    logic     cmp0_valid, cmp1_valid;
    preg_t    cmp0_ptag, cmp1_ptag;
    rob_idx_t cmp0_rob, cmp1_rob;
    word_t    cmp0_data, cmp1_data;

    // tags going back to the free list
    logic     free0_valid, free1_valid;
    preg_t    free0_ptag, free1_ptag;

    rename_unit    i_rename (.*);
    issue_queue    i_iq     (.*);
    exec_unit      i_exec   (.*);
    reorder_buffer i_rob    (.*);

endmodule

/* sim/tb_ooo_core.sv */
module tb_ooo_core
    import isa_pkg::*, ooo_pkg::*;
();

    localparam int TIMEOUT = 2000;

    typedef struct packed {
        opcode_t op;
        areg_t   rd;
        areg_t   rs1;
        areg_t   rs2;
        imm_t    imm;
        word_t   pc;
        logic    burst;
    } instr_t;

    typedef struct packed {
        areg_t rd;
        word_t data;
        word_t pc;
    } expect_t;

    logic    clk;
    logic    rstn;
    logic    in_valid;
    opcode_t in_opcode;
    areg_t   in_rd;
    areg_t   in_rs1;
    areg_t   in_rs2;
    imm_t    in_imm;
    word_t   in_pc;
    logic    stall;
    logic    retire0_valid;
    areg_t   retire0_rd;
    word_t   retire0_data;
    word_t   retire0_pc;
    logic    retire1_valid;
    areg_t   retire1_rd;
    word_t   retire1_data;
    word_t   retire1_pc;

    instr_t  instr_q [$];
    expect_t exp_q   [$];
    int      n_instr;
    int      n_retired;
    logic    stall_seen;

    ooo_core i_dut (.*);

    always #50 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR time %0t: %s got %h expected %h", $time, name, got, exp);
            $display("Simulation failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "run aborted");
    endtask

    // instruction lines go to instr_q, expected retirements to exp_q
    task automatic load_golden();
        int               fd;
        int               n;
        int               rd;
        int               rs1;
        int               rs2;
        int               burst;
        logic [7:0]       tag;
        logic [31:0]      op_name;
        logic [8*256-1:0] rest;
        imm_t             imm;
        word_t            pc;
        word_t            data;
        instr_t           ins;
        expect_t          ex;
        fd = $fopen("sim/golden_trace.txt", "r");
        if (fd == 0) begin
            stop_on_error("cannot open sim/golden_trace.txt");
        end else begin
            while (!$feof(fd)) begin
                n = $fscanf(fd, "%s", tag);
                if (n != 1) begin
                    break;
                end
                if (tag == "I") begin
                    n = $fscanf(fd, "%s %d %d %d %h %h %d", op_name, rd, rs1, rs2, imm, pc,
                                burst);
                    if (n != 7) begin
                        stop_on_error("malformed instruction line in golden trace");
                    end
                    case (op_name)
                        32'("ADD"):  ins.op = ADD;
                        32'("SUB"):  ins.op = SUB;
                        32'("AND"):  ins.op = AND;
                        32'("XOR"):  ins.op = XOR;
                        32'("ADDI"): ins.op = ADDI;
                        32'("MUL"):  ins.op = MUL;
                        default: stop_on_error("unknown opcode name in golden trace");
                    endcase
                    ins.rd    = areg_t'(rd);
                    ins.rs1   = areg_t'(rs1);
                    ins.rs2   = areg_t'(rs2);
                    ins.imm   = imm;
                    ins.pc    = pc;
                    ins.burst = (burst != 0);
                    instr_q.push_back(ins);
                end else if (tag == "R") begin
                    n = $fscanf(fd, "%d %h %h", rd, data, pc);
                    if (n != 3) begin
                        stop_on_error("malformed retire line in golden trace");
                    end
                    ex.rd   = areg_t'(rd);
                    ex.data = data;
                    ex.pc   = pc;
                    exp_q.push_back(ex);
                end else if (tag == "#") begin
                    n = $fgets(rest, fd);
                end else begin
                    stop_on_error("unknown line tag in golden trace");
                end
            end
            $fclose(fd);
        end
    endtask

    // present one instruction and hold it until an edge with stall low
    task automatic send_instr(input instr_t ins);
        int waited;
        in_valid  = 1'b1;
        in_opcode = ins.op;
        in_rd     = ins.rd;
        in_rs1    = ins.rs1;
        in_rs2    = ins.rs2;
        in_imm    = ins.imm;
        in_pc     = ins.pc;
        waited    = 0;
        // stall comes from registered state only, settled by the falling edge
        @(negedge clk);
        while (stall) begin
            waited++;
            if (waited >= TIMEOUT) begin
                stop_on_error("timeout: stall stayed high while an instruction waited");
            end else begin
                @(negedge clk);
            end
        end
        @(posedge clk);
        #10;
        in_valid = 1'b0;
    endtask

    task automatic match_retire(input int port, input areg_t rd, input word_t data,
                                input word_t pc);
        expect_t ex;
        if (exp_q.size() == 0) begin
            stop_on_error($sformatf("retire%0d at %0t with no expected entry left", port, $time));
        end else begin
            ex = exp_q.pop_front();
            n_retired++;
            check_value($sformatf("retire%0d_pc", port), pc, ex.pc);
            check_value($sformatf("retire%0d_rd", port), 32'(rd), 32'(ex.rd));
            check_value($sformatf("retire%0d_data", port), data, ex.data);
        end
    endtask

    // retire ports settle from registered ROB state before the falling edge
    always @(negedge clk) begin
        if (!rstn) begin
            check_value("retire0_valid", 32'(retire0_valid), 32'd0);
            check_value("retire1_valid", 32'(retire1_valid), 32'd0);
        end else begin
            if (stall) begin
                stall_seen = 1'b1;
            end
            check_value("retire1_valid without retire0_valid",
                        32'(retire1_valid & ~retire0_valid), 32'd0);
            if (retire0_valid) begin
                match_retire(0, retire0_rd, retire0_data, retire0_pc);
            end
            if (retire1_valid) begin
                match_retire(1, retire1_rd, retire1_data, retire1_pc);
            end
        end
    end

    initial begin
        int gap;
        int waited;
        void'($urandom(32'h91a2));
        clk        = 1'b0;
        rstn       = 1'b0;
        in_valid   = 1'b0;
        in_opcode  = ADD;
        in_rd      = '0;
        in_rs1     = '0;
        in_rs2     = '0;
        in_imm     = '0;
        in_pc      = '0;
        n_retired  = 0;
        stall_seen = 1'b0;
        load_golden();
        n_instr = instr_q.size();
        repeat (8) @(posedge clk);
        #10;
        rstn = 1'b1;
        check_value("stall", 32'(stall), 32'd0);
        foreach (instr_q[i]) begin
            // burst lines go back to back so the window fills up
            if (!instr_q[i].burst) begin
                gap = $urandom % 4;
                repeat (gap) begin
                    @(posedge clk);
                    #10;
                end
            end
            send_instr(instr_q[i]);
        end
        waited = 0;
        while (n_retired < n_instr && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (n_retired < n_instr) begin
            $display("timeout: only %0d of %0d instructions retired", n_retired, n_instr);
            $display("Simulation failed");
            $fatal(1, "drain timeout");
        end else begin
            // quiet window where a duplicated instruction would still show up
            repeat (4) @(posedge clk);
            // the dependent MUL burst has to back up the window at least once
            check_value("stall_seen", 32'(stall_seen), 32'd1);
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

/* sim/golden_trace.txt */
# I opcode rd rs1 rs2 imm(hex) pc(hex) burst, burst 1 sends it with no idle cycles before
# R rd data(hex) pc(hex), one line per instruction in program order
I ADDI 1 0 0 0007 00000100 0
I ADDI 2 0 0 fffd 00000104 0
I ADDI 3 0 0 1234 00000108 0
I MUL 4 1 3 0000 0000010c 0
I XOR 5 2 3 0000 00000110 1
I SUB 6 3 1 0000 00000114 1
I ADD 7 4 6 0000 00000118 0
I MUL 8 7 2 0000 0000011c 0
I AND 9 8 5 0000 00000120 0
I ADDI 1 1 0 0001 00000124 0
I ADD 10 1 1 0000 00000128 0
I MUL 1 1 10 0000 0000012c 0
I XOR 11 1 10 0000 00000130 0
I MUL 12 1 10 0000 00000134 0
I MUL 13 12 10 0000 00000138 1
I MUL 14 13 10 0000 0000013c 1
I ADDI 15 14 0 0001 00000140 1
I ADD 16 14 3 0000 00000144 1
I SUB 17 14 11 0000 00000148 1
I XOR 18 14 2 0000 0000014c 1
I AND 19 14 5 0000 00000150 1
I ADD 20 14 14 0000 00000154 1
I ADDI 21 14 0 ffff 00000158 1
I SUB 22 14 10 0000 0000015c 1
I ADDI 1 14 0 0010 00000160 1
R 1 00000007 00000100
R 2 fffffffd 00000104
R 3 00001234 00000108
R 4 00007f6c 0000010c
R 5 ffffedc9 00000110
R 6 0000122d 00000114
R 7 00009199 00000118
R 8 fffe4b35 0000011c
R 9 fffe4901 00000120
R 1 00000008 00000124
R 10 00000010 00000128
R 1 00000080 0000012c
R 11 00000090 00000130
R 12 00000800 00000134
R 13 00008000 00000138
R 14 00080000 0000013c
R 15 00080001 00000140
R 16 00081234 00000144
R 17 0007ff70 00000148
R 18 fff7fffd 0000014c
R 19 00080000 00000150
R 20 00100000 00000154
R 21 0007ffff 00000158
R 22 0007fff0 0000015c
R 1 00080010 00000160

/* vlog.f */
+incdir+src
src/isa_pkg.sv
src/ooo_pkg.sv
src/rename_unit.sv
src/issue_queue.sv
src/exec_unit.sv
src/reorder_buffer.sv
src/ooo_core.sv
sim/tb_ooo_core.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tb_ooo_core
FILELIST  := vlog.f
VFLAGS    := --binary --timing -j 0 --top-module $(TOP)

OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := Simulation completed successfully
SOURCES   := $(shell grep -v '^+' $(FILELIST)) src/ooo_params.svh

.PHONY: all run clean

all: run

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
